// ==== memSystem.f ====
verilog/memSysPkg.sv
verilog/instrCache.sv
verilog/dataCache.sv
verilog/busArbiter.sv
verilog/ahbMemory.sv
verilog/memSystem.sv
test/memSystemTb.sv

// ==== test/memSystemTb.sv ====
`timescale 1ns/1ps

module memSystemTb;
  import memSysPkg::*;

  localparam int ClkPeriod = 4;
  localparam int NumOps    = 300;

  logic                 clk;
  logic                 rst;
  logic [AddrWidth-1:0] pcF;
  logic                 iEnable;
  logic                 invI;
  logic [DataWidth-1:0] instrF;
  logic                 iStall;
  logic                 memWriteM;
  logic                 memReadM;
  logic [AddrWidth-1:0] dataAdrM;
  logic [DataWidth-1:0] writeDataM;
  logic [MaskWidth-1:0] byteMaskM;
  logic                 dEnable;
  logic                 invD;
  logic [DataWidth-1:0] readDataM;
  logic                 dStall;

  // Reference memory and the testbench's view of the instruction cache
  logic [DataWidth-1:0]  refMem [MemWords];
  logic [DataWidth-1:0]  iLine [InstrLines][BlockWords];
  logic [TagBits-1:0]    iTag [InstrLines];
  logic [InstrLines-1:0] iValid;

  // Pending comparisons
  string                nameQ [$];
  logic [DataWidth-1:0] expQ [$];
  logic [DataWidth-1:0] actQ [$];
  int                   issued = 0;
  int                   checked = 0;
  int                   errorCount = 0;

  memSystem u_memSystem (.*);

  initial begin
    clk = 1'b0;
    forever #(ClkPeriod / 2) clk = ~clk;
  end

  function automatic logic [DataWidth-1:0] refLoad(input logic [AddrWidth-1:0] adr);
    return refMem[adr[ByteBits +: MemAddrBits]];
  endfunction

  function automatic logic [DataWidth-1:0] mergeStore(input logic [DataWidth-1:0] old,
                                                      input logic [DataWidth-1:0] wdata,
                                                      input logic [MaskWidth-1:0] mask);
    logic [DataWidth-1:0] bitMask;
    bitMask = {{8{mask[3]}}, {8{mask[2]}}, {8{mask[1]}}, {8{mask[0]}}};
    return (old & ~bitMask) | (wdata & bitMask);
  endfunction

  // Stale words come back while the modeled line is still valid
  function automatic logic [DataWidth-1:0] refFetch(input logic [AddrWidth-1:0] adr);
    logic [IndexBits-1:0] idx;
    logic [TagBits-1:0]   tag;
    idx = adr[ByteBits+OffsetBits +: IndexBits];
    tag = adr[AddrWidth-1 -: TagBits];
    if (!(iValid[idx] && iTag[idx] == tag)) begin
      for (int w = 0; w < BlockWords; w++) begin
        iLine[idx][w] = refLoad({adr[AddrWidth-1:4], 4'b0} + w * 4);
      end
      iTag[idx]   = tag;
      iValid[idx] = 1'b1;
    end
    return iLine[idx][adr[ByteBits +: OffsetBits]];
  endfunction

  task automatic nextDrivePoint;
    @(posedge clk);
    #1;
  endtask

  task automatic postCheck(input string name, input logic [DataWidth-1:0] expVal,
                           input logic [DataWidth-1:0] actVal);
    nameQ.push_back(name);
    expQ.push_back(expVal);
    actQ.push_back(actVal);
    issued++;
  endtask

  task automatic checkStall(input int stalls, input bit missExpected, input string what);
    if ((stalls > 0) != missExpected) begin
      $display("%s: stall was %0sexpected but it lasted %0d cycles",
               what, missExpected ? "" : "not ", stalls);
      errorCount++;
    end
  endtask

  task automatic loadWord(input logic [AddrWidth-1:0] adr, output int stallCycles);
    memReadM    = 1'b1;
    dataAdrM    = adr;
    stallCycles = 0;
    @(negedge clk);
    while (dStall) begin
      stallCycles++;
      @(negedge clk);
    end
    postCheck("readDataM", refLoad(adr), readDataM);
    nextDrivePoint();
    memReadM = 1'b0;
  endtask

  task automatic storeWord(input logic [AddrWidth-1:0] adr, input logic [DataWidth-1:0] data,
                           input logic [MaskWidth-1:0] mask);
    memWriteM  = 1'b1;
    dataAdrM   = adr;
    writeDataM = data;
    byteMaskM  = mask;
    @(negedge clk);
    while (dStall) @(negedge clk);
    refMem[adr[ByteBits +: MemAddrBits]] = mergeStore(refLoad(adr), data, mask);
    nextDrivePoint();
    memWriteM = 1'b0;
  endtask

  task automatic fetchWord(input logic [AddrWidth-1:0] adr, output int stallCycles);
    // Old pc stays put until a background refill is done
    @(negedge clk);
    while (iStall) @(negedge clk);
    nextDrivePoint();
    pcF         = adr;
    stallCycles = 0;
    @(negedge clk);
    while (iStall) begin
      stallCycles++;
      @(negedge clk);
    end
    postCheck("instrF", refFetch(adr), instrF);
    nextDrivePoint();
  endtask

  task automatic pulseInvalidate(input bit instrSide);
    if (instrSide) begin
      invI   = 1'b1;
      iValid = '0;
    end else begin
      invD = 1'b1;
    end
    nextDrivePoint();
    invI = 1'b0;
    invD = 1'b0;
  endtask

  initial begin : compareResults
    string                name;
    logic [DataWidth-1:0] expVal;
    logic [DataWidth-1:0] actVal;
    forever begin
      wait (actQ.size() > 0);
      name   = nameQ.pop_front();
      expVal = expQ.pop_front();
      actVal = actQ.pop_front();
      if (actVal !== expVal) begin
        $display("Fail %s expected %h got %h", name, expVal, actVal);
        errorCount++;
      end
      checked++;
    end
  end

  initial begin : watchdog
    #(NumOps * 40 * ClkPeriod);
    $display("Timeout: the run did not finish within %0d ns", NumOps * 40 * ClkPeriod);
    $display("Test failed");
    $finish;
  end

  initial begin
    int                   stalls;
    int                   fetchStalls;
    logic [AddrWidth-1:0] adr;
    void'($urandom(32'h4af6));
    rst        = 1'b1;
    pcF        = '0;
    iEnable    = 1'b1;
    invI       = 1'b0;
    memWriteM  = 1'b0;
    memReadM   = 1'b0;
    dataAdrM   = '0;
    writeDataM = '0;
    byteMaskM  = '0;
    dEnable    = 1'b1;
    invD       = 1'b0;
    iValid     = '0;
    for (int i = 0; i < MemWords; i++) begin
      refMem[i] = '0;
    end
    repeat (2) @(posedge clk);
    #1;
    rst = 1'b0;

    // Byte-masked stores, then loads of the merged words
    storeWord(32'h040, 32'h11223344, 4'hf);
    storeWord(32'h040, 32'haabbccdd, 4'b0101);
    storeWord(32'h044, 32'h55667788, 4'b1000);
    storeWord(32'h048, 32'h99aabbcc, 4'b0011);
    storeWord(32'h04c, 32'hdeadbeef, 4'b0110);
    for (int k = 0; k < 4; k++) begin
      loadWord(32'h040 + k * 4, stalls);
    end
    storeWord(32'h044, 32'h000000ff, 4'b0001);
    loadWord(32'h044, stalls);
    checkStall(stalls, 1'b0, "Load after store hit at 044");

    // Second word of a freshly filled block hits
    storeWord(32'h084, 32'h0badf00d, 4'hf);
    loadWord(32'h080, stalls);
    loadWord(32'h084, stalls);
    checkStall(stalls, 1'b0, "Load of second word at 084");

    // Instruction side sees the old word until invalidated
    fetchWord(32'h300, fetchStalls);
    checkStall(fetchStalls, 1'b1, "First fetch at 300");
    storeWord(32'h300, 32'hcafef00d, 4'hf);
    fetchWord(32'h300, fetchStalls);
    checkStall(fetchStalls, 1'b0, "Cached fetch at 300 after store");
    pulseInvalidate(1'b1);
    fetchWord(32'h300, fetchStalls);

    // Uncached loads, then a miss after invalidate
    dEnable = 1'b0;
    repeat (2) begin
      loadWord(32'h048, stalls);
      checkStall(stalls, 1'b1, "Uncached load at 048");
    end
    dEnable = 1'b1;
    pulseInvalidate(1'b0);
    loadWord(32'h040, stalls);
    checkStall(stalls, 1'b1, "Load at 040 after data invalidate");

    // Both ports busy at once
    storeWord(32'h100, 32'h01000001, 4'hf);
    storeWord(32'h1a4, 32'h01a40002, 4'hf);
    storeWord(32'h240, 32'h02400003, 4'hf);
    storeWord(32'h2c8, 32'h02c80004, 4'hf);
    fork
      fetchWord(32'h100, fetchStalls);
      loadWord(32'h240, stalls);
    join
    fork
      fetchWord(32'h1a4, fetchStalls);
      loadWord(32'h2c8, stalls);
    join

    // Random mix, instruction side invalidated after every store
    for (int n = 0; n < 200; n++) begin
      adr = 32'h400 + (($urandom % 64) << 2);
      case ($urandom % 3)
        0: loadWord(adr, stalls);
        1: fetchWord(adr, fetchStalls);
        default: begin
          storeWord(adr, $urandom, $urandom % 16);
          pulseInvalidate(1'b1);
        end
      endcase
    end

    wait (checked == issued);
    $display("Finished %0d value checks with %0d errors", checked, errorCount);
    if (errorCount == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

// ==== verilog/memSystem.sv ====
`timescale 1ns/1ps

module memSystem (
  input  logic                            clk,
  input  logic                            rst,
  input  logic [memSysPkg::AddrWidth-1:0] pcF,
  input  logic                            iEnable,
  input  logic                            invI,
  output logic [memSysPkg::DataWidth-1:0] instrF,
  output logic                            iStall,
  input  logic                            memWriteM,
  input  logic                            memReadM,
  input  logic [memSysPkg::AddrWidth-1:0] dataAdrM,
  input  logic [memSysPkg::DataWidth-1:0] writeDataM,
  input  logic [memSysPkg::MaskWidth-1:0] byteMaskM,
  input  logic                            dEnable,
  input  logic                            invD,
  output logic [memSysPkg::DataWidth-1:0] readDataM,
  output logic                            dStall
);
  import memSysPkg::*;

  // Cache side of the arbiter
  logic                 hRequestF, busReadyF;
  logic                 hRequestM, hWriteM, busReadyM;
  logic [AddrWidth-1:0] hAddrF, hAddrM;
  logic [DataWidth-1:0] hWDataM;

  // Shared bus
  logic                 hRequest, hWrite, hReady;
  logic [AddrWidth-1:0] hAddr;
  logic [DataWidth-1:0] hWData, hRData;

  instrCache u_instrCache (
    .clk       (clk       ),
    .rst       (rst       ),
    .enable    (iEnable   ),
    .invalidate(invI      ),
    .pc        (pcF       ),
    .hRData    (hRData    ),
    .busReady  (busReadyF ),
    .instr     (instrF    ),
    .stall     (iStall    ),
    .hAddr     (hAddrF    ),
    .hRequest  (hRequestF )
  );

  dataCache u_dataCache (
    .clk       (clk       ),
    .rst       (rst       ),
    .enable    (dEnable   ),
    .invalidate(invD      ),
    .memWrite  (memWriteM ),
    .memRead   (memReadM  ),
    .adr       (dataAdrM  ),
    .wd        (writeDataM),
    .byteMask  (byteMaskM ),
    .hRData    (hRData    ),
    .busReady  (busReadyM ),
    .rd        (readDataM ),
    .stall     (dStall    ),
    .hAddr     (hAddrM    ),
    .hWData    (hWDataM   ),
    .hRequest  (hRequestM ),
    .hWrite    (hWriteM   )
  );

  busArbiter u_busArbiter (
    .clk      (clk      ),
    .rst      (rst      ),
    .hRequestF(hRequestF),
    .hRequestM(hRequestM),
    .hWriteM  (hWriteM  ),
    .hAddrF   (hAddrF   ),
    .hAddrM   (hAddrM   ),
    .hWDataM  (hWDataM  ),
    .hReady   (hReady   ),
    .busReadyF(busReadyF),
    .busReadyM(busReadyM),
    .hRequest (hRequest ),
    .hWrite   (hWrite   ),
    .hAddr    (hAddr    ),
    .hWData   (hWData   )
  );

  ahbMemory u_ahbMemory (
    .clk     (clk     ),
    .rst     (rst     ),
    .hRequest(hRequest),
    .hWrite  (hWrite  ),
    .hAddr   (hAddr   ),
    .hWData  (hWData  ),
    .hRData  (hRData  ),
    .hReady  (hReady  )
  );

endmodule

// ==== verilog/ahbMemory.sv ====
`timescale 1ns/1ps

module ahbMemory (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            hRequest,
  input  logic                            hWrite,
  input  logic [memSysPkg::AddrWidth-1:0] hAddr,
  input  logic [memSysPkg::DataWidth-1:0] hWData,
  output logic [memSysPkg::DataWidth-1:0] hRData,
  output logic                            hReady
);
  import memSysPkg::*;

  logic [DataWidth-1:0]   mem [MemWords];
  logic [MemAddrBits-1:0] wordAdr;
  logic                   accept;

  // Word address, upper bits alias
  assign wordAdr = hAddr[ByteBits +: MemAddrBits];

  // No new beat while the previous one is being answered
  assign accept = hRequest && !hReady;

  initial begin
    for (int i = 0; i < MemWords; i++) begin
      mem[i] = '0;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) hReady <= 1'b0;
    else hReady <= accept;
  end

  always @(posedge clk) begin
    if (accept && hWrite) mem[wordAdr] <= hWData;
  end

  // Read data lines up with hReady
  always_ff @(posedge clk) begin
    if (accept && !hWrite) hRData <= mem[wordAdr];
  end

endmodule

// ==== verilog/busArbiter.sv ====
`timescale 1ns/1ps

module busArbiter (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            hRequestF,
  input  logic                            hRequestM,
  input  logic                            hWriteM,
  input  logic [memSysPkg::AddrWidth-1:0] hAddrF,
  input  logic [memSysPkg::AddrWidth-1:0] hAddrM,
  input  logic [memSysPkg::DataWidth-1:0] hWDataM,
  input  logic                            hReady,
  output logic                            busReadyF,
  output logic                            busReadyM,
  output logic                            hRequest,
  output logic                            hWrite,
  output logic [memSysPkg::AddrWidth-1:0] hAddr,
  output logic [memSysPkg::DataWidth-1:0] hWData
);

  typedef enum logic [1:0] {
    OwnNone,
    OwnFetch,
    OwnData
  } ownerT;

  ownerT owner;
  ownerT grant;

  // Current owner holds while requesting, otherwise data side first
  always_comb begin
    if (owner == OwnFetch && hRequestF) grant = OwnFetch;
    else if (owner == OwnData && hRequestM) grant = OwnData;
    else if (hRequestM) grant = OwnData;
    else if (hRequestF) grant = OwnFetch;
    else grant = OwnNone;
  end

  always_ff @(posedge clk) begin
    if (rst) owner <= OwnNone;
    else owner <= grant;
  end

  assign hRequest  = (grant != OwnNone);
  assign hWrite    = (grant == OwnData) && hWriteM;
  assign hAddr     = (grant == OwnData) ? hAddrM : hAddrF;
  assign hWData    = (grant == OwnData) ? hWDataM : '0;

  // Ready goes back to the owner only
  assign busReadyF = hReady && (grant == OwnFetch);
  assign busReadyM = hReady && (grant == OwnData);

endmodule

// ==== verilog/dataCache.sv ====
`timescale 1ns/1ps

module dataCache (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            enable,
  input  logic                            invalidate,
  input  logic                            memWrite,
  input  logic                            memRead,
  input  logic [memSysPkg::AddrWidth-1:0] adr,
  input  logic [memSysPkg::DataWidth-1:0] wd,
  input  logic [memSysPkg::MaskWidth-1:0] byteMask,
  input  logic [memSysPkg::DataWidth-1:0] hRData,
  input  logic                            busReady,
  output logic [memSysPkg::DataWidth-1:0] rd,
  output logic                            stall,
  output logic [memSysPkg::AddrWidth-1:0] hAddr,
  output logic [memSysPkg::DataWidth-1:0] hWData,
  output logic                            hRequest,
  output logic                            hWrite
);
  import memSysPkg::*;

  typedef enum logic [2:0] {
    Idle,
    Fill,
    Single,
    ReadOld,
    Write
  } stateT;

  stateT                 state;
  logic [OffsetBits-1:0] beat;
  logic                  lastBeat;
  logic                  storeHit;
  logic [DataLines-1:0]  valid;
  logic [TagBits-1:0]    tagArr [DataLines];
  logic [DataWidth-1:0]  lineData [DataLines*BlockWords];

  logic [TagBits-1:0]    tag;
  logic [IndexBits-1:0]  index;
  logic [OffsetBits-1:0] offset;
  logic                  hit;
  logic [DataWidth-1:0]  cachedWord;
  logic [DataWidth-1:0]  oldWord;
  logic [DataWidth-1:0]  mergedWord;

  function automatic logic [DataWidth-1:0] mergeBytes(
    input logic [DataWidth-1:0] base,
    input logic [DataWidth-1:0] newData,
    input logic [MaskWidth-1:0] mask
  );
    logic [DataWidth-1:0] merged;
    merged = base;
    for (int b = 0; b < MaskWidth; b++) begin
      if (mask[b]) merged[8*b +: 8] = newData[8*b +: 8];
    end
    return merged;
  endfunction

  assign tag        = adr[AddrWidth-1 -: TagBits];
  assign index      = adr[ByteBits+OffsetBits +: IndexBits];
  assign offset     = adr[ByteBits +: OffsetBits];
  assign hit        = valid[index] && (tagArr[index] == tag);
  assign lastBeat   = (beat == BlockWords - 1);
  assign cachedWord = lineData[{index, offset}];
  assign mergedWord = mergeBytes(oldWord, wd, byteMask);

  assign rd       = (state == Single) ? hRData : cachedWord;
  assign hWData   = mergedWord;
  assign hWrite   = (state == Write);
  assign hRequest = (state != Idle);
  assign hAddr = (state == Fill) ?
                 {adr[AddrWidth-1:ByteBits+OffsetBits], beat, {ByteBits{1'b0}}} :
                 {adr[AddrWidth-1:ByteBits], {ByteBits{1'b0}}};

  // Only an enabled read hit finishes without the bus
  always_comb begin
    case (state)
      Fill, ReadOld:  stall = 1'b1;
      Single, Write:  stall = !busReady;
      default:        stall = memWrite || (memRead && !(enable && hit));
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state    <= Idle;
      beat     <= '0;
      storeHit <= 1'b0;
    end else begin
      case (state)
        Idle: begin
          if (memWrite) begin
            storeHit <= hit;
            state    <= hit ? Write : ReadOld;
          end else if (memRead && !enable) begin
            state <= Single;
          end else if (memRead && !hit) begin
            state <= Fill;
          end
        end
        Fill: begin
          if (busReady) begin
            beat <= beat + 1'b1;
            if (lastBeat) state <= Idle;
          end
        end
        ReadOld: begin
          if (busReady) state <= Write;
        end
        Single, Write: begin
          if (busReady) state <= Idle;
        end
        default: state <= Idle;
      endcase
    end
  end

  // Word to merge into: cached copy on a hit, else the old memory word
  always_ff @(posedge clk) begin
    if (state == Idle && memWrite) oldWord <= cachedWord;
    else if (state == ReadOld && busReady) oldWord <= hRData;
  end

  always_ff @(posedge clk) begin
    if (rst || invalidate) valid <= '0;
    else if (state == Fill && busReady && lastBeat) valid[index] <= 1'b1;
  end

  // Store hits update the line even while disabled, so it stays coherent
  always_ff @(posedge clk) begin
    if (state == Fill && busReady) begin
      lineData[{index, beat}] <= hRData;
      if (lastBeat) tagArr[index] <= tag;
    end else if (state == Write && busReady && storeHit) begin
      lineData[{index, offset}] <= mergedWord;
    end
  end

endmodule

// ==== verilog/instrCache.sv ====
`timescale 1ns/1ps

module instrCache (
  input  logic                            clk,
  input  logic                            rst,
  input  logic                            enable,
  input  logic                            invalidate,
  input  logic [memSysPkg::AddrWidth-1:0] pc,
  input  logic [memSysPkg::DataWidth-1:0] hRData,
  input  logic                            busReady,
  output logic [memSysPkg::DataWidth-1:0] instr,
  output logic                            stall,
  output logic [memSysPkg::AddrWidth-1:0] hAddr,
  output logic                            hRequest
);
  import memSysPkg::*;

  typedef enum logic [1:0] {
    Idle,
    Fill,
    Single
  } stateT;

  stateT                 state;
  logic [OffsetBits-1:0] beat;
  logic                  lastBeat;
  logic [InstrLines-1:0] valid;
  logic [TagBits-1:0]    tagArr [InstrLines];
  logic [DataWidth-1:0]  lineData [InstrLines*BlockWords];

  logic [TagBits-1:0]    tag;
  logic [IndexBits-1:0]  index;
  logic [OffsetBits-1:0] offset;
  logic                  hit;

  assign tag      = pc[AddrWidth-1 -: TagBits];
  assign index    = pc[ByteBits+OffsetBits +: IndexBits];
  assign offset   = pc[ByteBits +: OffsetBits];
  assign hit      = valid[index] && (tagArr[index] == tag);
  assign lastBeat = (beat == BlockWords - 1);

  // Uncached fetch returns the bus word directly
  assign instr    = (state == Single) ? hRData : lineData[{index, offset}];
  assign hRequest = (state != Idle);

  // Fills walk the block from word 0
  assign hAddr = (state == Fill) ?
                 {pc[AddrWidth-1:ByteBits+OffsetBits], beat, {ByteBits{1'b0}}} :
                 {pc[AddrWidth-1:ByteBits], {ByteBits{1'b0}}};

  always_comb begin
    case (state)
      Fill:    stall = 1'b1;
      Single:  stall = !busReady;
      default: stall = !(enable && hit);
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= Idle;
      beat  <= '0;
    end else begin
      case (state)
        Idle: begin
          if (!enable) state <= Single;
          else if (!hit) state <= Fill;
        end
        Fill: begin
          if (busReady) begin
            beat <= beat + 1'b1;
            if (lastBeat) state <= Idle;
          end
        end
        Single: begin
          if (busReady) state <= Idle;
        end
        default: state <= Idle;
      endcase
    end
  end

  // Line becomes valid with its last word
  always_ff @(posedge clk) begin
    if (rst || invalidate) valid <= '0;
    else if (state == Fill && busReady && lastBeat) valid[index] <= 1'b1;
  end

  always_ff @(posedge clk) begin
    if (state == Fill && busReady) begin
      lineData[{index, beat}] <= hRData;
      if (lastBeat) tagArr[index] <= tag;
    end
  end

endmodule

// ==== verilog/memSysPkg.sv ====
package memSysPkg;

  // Bus and word sizes
  localparam int AddrWidth = 32;
  localparam int DataWidth = 32;
  localparam int MaskWidth = DataWidth / 8;

  // Cache geometry, both caches direct mapped
  localparam int BlockWords = 4;
  localparam int InstrLines = 16;
  localparam int DataLines  = 16;

  // Memory model depth; upper address bits alias
  localparam int MemWords = 1024;

  // Address field widths
  localparam int ByteBits    = $clog2(DataWidth / 8);
  localparam int OffsetBits  = $clog2(BlockWords);
  localparam int IndexBits   = $clog2(DataLines);
  localparam int TagBits     = AddrWidth - IndexBits - OffsetBits - ByteBits;
  localparam int MemAddrBits = $clog2(MemWords);

endpackage
